// ==== dv/tb_ex_checks.svh ====
// Result compare tasks and reference models
`ifndef TB_EX_CHECKS_SVH
`define TB_EX_CHECKS_SVH

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  // Full write port with all three fields at once
  task automatic check_wr(input string name, input rf_wr_t exp, input rf_wr_t got);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Error at %0d ns: %s expected we=%b waddr=%0d wdata=%h, got we=%b waddr=%0d wdata=%h",
               $time, name, exp.we, exp.waddr, exp.wdata, got.we, got.waddr, got.wdata);
    end
  endtask

  task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] got);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Error at %0d ns: %s expected %h, got %h", $time, name, exp, got);
    end
  endtask

  // Single flags such as ready, valid and branch taken
  task automatic check_bit(input string name, input logic exp, input logic got);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Error at %0d ns: %s expected %b, got %b", $time, name, exp, got);
    end
  endtask

  ////////////////////////////////////////
  // Reference models
  ////////////////////////////////////////

  // Branch taken per RISC-V compare semantics
  function automatic logic branch_ref(alu_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    case (op)
      ALU_EQ:  return a == b;
      ALU_NE:  return a != b;
      ALU_LT:  return $signed(a) < $signed(b);
      ALU_GE:  return $signed(a) >= $signed(b);
      ALU_LTU: return a < b;
      ALU_GEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] alu_ref(alu_op_e op, logic [XLEN-1:0] a,
                                              logic [XLEN-1:0] b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_XOR:  return a ^ b;
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      // Shift amount is the low five bits of b
      ALU_SLL:  return a << b[SHAMT_W-1:0];
      ALU_SRL:  return a >> b[SHAMT_W-1:0];
      // Vacated top bits take copies of the sign
      ALU_SRA:  return (a >> b[SHAMT_W-1:0]) |
                       (a[XLEN-1] ? ~({XLEN{1'b1}} >> b[SHAMT_W-1:0]) : '0);
      ALU_SLT:  return {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
      ALU_SLTU: return {{(XLEN-1){1'b0}}, (a < b)};
      default:  return {{(XLEN-1){1'b0}}, branch_ref(op, a, b)};
    endcase
  endfunction

  // Upper word of the signed 64-bit product
  function automatic logic [XLEN-1:0] mulh_ref(logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    logic signed [2*XLEN-1:0] sa;
    logic signed [2*XLEN-1:0] sb;
    logic signed [2*XLEN-1:0] p;
    sa = {{XLEN{a[XLEN-1]}}, a};
    sb = {{XLEN{b[XLEN-1]}}, b};
    p  = sa * sb;
    return p[2*XLEN-1:XLEN];
  endfunction

`endif

// ==== dv/tb_ex_stage.sv ====
// Execute stage testbench
`timescale 1ns/10ps
`default_nettype none

module tb_ex_stage
  import ex_pkg::*;
();

  localparam int          CLK_PERIOD = 4;
  localparam int unsigned SEED       = 32'h4516_0191;
  localparam int          N_ALU      = 60;
  localparam int          N_BR       = 8;   // per compare opcode
  localparam int          N_MUL      = 6;
  localparam int          N_ACC      = 16;
  // Cycle budget of all tests including reset
  localparam int TOTAL_CYC   = 8 + (N_ALU + 2) + (6 * N_BR + 2) + (3 * N_MUL + 2) +
                               (N_ACC + 8) + 12 + 8;
  localparam int WATCHDOG_NS = TOTAL_CYC * CLK_PERIOD + 200;

  logic                 clk;
  logic                 rst_n;
  alu_req_t             alu_req;
  mul_req_t             mul_req;
  cml_req_t             cml_req;
  logic                 csr_access;
  logic [XLEN-1:0]      csr_rdata;
  logic                 regfile_alu_we;
  logic [RF_ADDR_W-1:0] regfile_alu_waddr;
  logic                 regfile_we;
  logic [RF_ADDR_W-1:0] regfile_waddr;
  logic                 lsu_en;
  logic [XLEN-1:0]      lsu_rdata;
  logic                 lsu_ready_ex;
  logic                 lsu_err;
  logic                 branch_in_ex;
  logic                 wb_ready;
  rf_wr_t               fw_wr;
  rf_wr_t               wb_wr;
  logic [XLEN-1:0]      jump_target;
  logic                 branch_decision;
  logic                 mult_multicycle;
  logic                 ex_ready;
  logic                 ex_valid;

  int    err_cnt   = 0;
  int    check_cnt = 0;
  int    test_cnt  = 0;
  int    test_err_base;
  string cur_test;

  `include "tb_ex_checks.svh"

  ex_stage ex_stage_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_req_i           (alu_req),
    .mul_req_i           (mul_req),
    .cml_req_i           (cml_req),
    .csr_access_i        (csr_access),
    .csr_rdata_i         (csr_rdata),
    .regfile_alu_we_i    (regfile_alu_we),
    .regfile_alu_waddr_i (regfile_alu_waddr),
    .regfile_we_i        (regfile_we),
    .regfile_waddr_i     (regfile_waddr),
    .lsu_en_i            (lsu_en),
    .lsu_rdata_i         (lsu_rdata),
    .lsu_ready_ex_i      (lsu_ready_ex),
    .lsu_err_i           (lsu_err),
    .branch_in_ex_i      (branch_in_ex),
    .wb_ready_i          (wb_ready),
    .fw_wr_o             (fw_wr),
    .wb_wr_o             (wb_wr),
    .jump_target_o       (jump_target),
    .branch_decision_o   (branch_decision),
    .mult_multicycle_o   (mult_multicycle),
    .ex_ready_o          (ex_ready),
    .ex_valid_o          (ex_valid)
  );

  ////////////////////////////////////////
  // Clock and watchdog
  ////////////////////////////////////////

  initial begin
    clk = 1'b0;
  end
  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Quiet stage with all sinks ready
  task automatic idle_inputs();
    alu_req           = '0;
    alu_req.op        = ALU_ADD;
    mul_req           = '0;
    cml_req           = '0;
    csr_access        = 1'b0;
    csr_rdata         = '0;
    regfile_alu_we    = 1'b0;
    regfile_alu_waddr = '0;
    regfile_we        = 1'b0;
    regfile_waddr     = '0;
    lsu_en            = 1'b0;
    lsu_rdata         = '0;
    lsu_ready_ex      = 1'b1;
    lsu_err           = 1'b0;
    branch_in_ex      = 1'b0;
    wb_ready          = 1'b1;
  endtask

  // Inputs change 1 ns after the rising edge and outputs are sampled at the falling edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic start_test(input string name);
    cur_test      = name;
    test_err_base = err_cnt;
  endtask

  task automatic finish_test();
    int errs;
    errs = err_cnt - test_err_base;
    test_cnt++;
    if (errs == 0) begin
      $display("Test %s ok", cur_test);
    end else begin
      $display("Test %s FAILED with %0d errors", cur_test, errs);
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  // Sampled before the first edge after reset release
  task automatic test_reset_state();
    start_test("reset_state");
    cml_req.get = 1'b1;
    @(negedge clk);
    check_bit("wb_wr_o.we", 1'b0, wb_wr.we);
    check_word("fw_wr_o.wdata", '0, fw_wr.wdata);
    next_cycle();
    idle_inputs();
    finish_test();
  endtask

  task automatic test_alu_ops();
    alu_op_e         ops [10];
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    rf_wr_t          exp;
    ops = '{ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
            ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU};
    start_test("alu_ops");
    for (int i = 0; i < N_ALU; i++) begin
      next_cycle();
      a = $urandom;
      // Equal operands now and then
      b = (i % 7 == 3) ? a : $urandom;
      alu_req.en        = 1'b1;
      alu_req.op        = ops[i % 10];
      alu_req.a         = a;
      alu_req.b         = b;
      regfile_alu_we    = 1'($urandom);
      regfile_alu_waddr = RF_ADDR_W'($urandom);
      @(negedge clk);
      exp.we    = regfile_alu_we;
      exp.waddr = regfile_alu_waddr;
      exp.wdata = alu_ref(ops[i % 10], a, b);
      check_wr("fw_wr_o", exp, fw_wr);
    end
    next_cycle();
    idle_inputs();
    finish_test();
  endtask

  task automatic test_branches();
    alu_op_e         ops [6];
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] c;
    ops = '{ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};
    start_test("branches");
    foreach (ops[k]) begin
      for (int i = 0; i < N_BR; i++) begin
        next_cycle();
        a = $urandom;
        c = $urandom;
        case (i % 4)
          0:       b = a;
          1:       b = ~a;      // opposite sign
          default: b = $urandom;
        endcase
        alu_req.en = 1'b1;
        alu_req.op = ops[k];
        alu_req.a  = a;
        alu_req.b  = b;
        alu_req.c  = c;
        @(negedge clk);
        check_bit("branch_decision_o", branch_ref(ops[k], a, b), branch_decision);
        check_word("jump_target_o", c, jump_target);
      end
    end
    next_cycle();
    idle_inputs();
    finish_test();
  endtask

  task automatic test_mult();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    start_test("multiplier");
    for (int i = 0; i < N_MUL; i++) begin
      // Most negative operands first
      a = (i == 0) ? 32'h8000_0000 : $urandom;
      b = (i == 0) ? 32'h8000_0000 : $urandom;
      next_cycle();
      mul_req.en = 1'b1;
      mul_req.op = MUL_LO;
      mul_req.a  = a;
      mul_req.b  = b;
      @(negedge clk);
      check_word("fw_wr_o.wdata", a * b, fw_wr.wdata);
      check_bit("mult_multicycle_o", 1'b0, mult_multicycle);
      check_bit("ex_ready_o", 1'b1, ex_ready);
      // High product stalls for one cycle
      next_cycle();
      mul_req.op = MUL_HS;
      @(negedge clk);
      check_bit("mult_multicycle_o", 1'b1, mult_multicycle);
      check_bit("ex_ready_o", 1'b0, ex_ready);
      // Request held by ID while the high word comes out
      next_cycle();
      @(negedge clk);
      check_word("fw_wr_o.wdata", mulh_ref(a, b), fw_wr.wdata);
      check_bit("mult_multicycle_o", 1'b0, mult_multicycle);
      check_bit("ex_ready_o", 1'b1, ex_ready);
    end
    next_cycle();
    idle_inputs();
    finish_test();
  endtask

  task automatic test_accum();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] sum;
    start_test("accumulator");
    next_cycle();
    cml_req.clr = 1'b1;
    sum = '0;
    for (int i = 0; i < N_ACC; i++) begin
      next_cycle();
      a = $urandom;
      b = $urandom;
      cml_req.clr = 1'b0;
      cml_req.en  = 1'b1;
      cml_req.a   = a;
      cml_req.b   = b;
      @(negedge clk);
      // Port shows the stored sum before this pair lands
      check_word("fw_wr_o.wdata", sum, fw_wr.wdata);
      sum = sum + a + b;
    end
    next_cycle();
    cml_req.en  = 1'b0;
    cml_req.get = 1'b1;
    @(negedge clk);
    check_word("fw_wr_o.wdata", sum, fw_wr.wdata);
    // Clear beats a simultaneous update
    next_cycle();
    cml_req.get = 1'b0;
    cml_req.clr = 1'b1;
    cml_req.en  = 1'b1;
    next_cycle();
    cml_req.clr = 1'b0;
    cml_req.en  = 1'b0;
    cml_req.get = 1'b1;
    @(negedge clk);
    check_word("fw_wr_o.wdata", '0, fw_wr.wdata);
    next_cycle();
    idle_inputs();
    finish_test();
  endtask

  task automatic test_load_wb();
    rf_wr_t               exp;
    logic [RF_ADDR_W-1:0] addr_ok;
    logic [RF_ADDR_W-1:0] addr_err;
    logic [RF_ADDR_W-1:0] addr_bp;
    start_test("load_wb");
    addr_ok  = 6'd17;
    addr_err = 6'd42;
    addr_bp  = 6'd5;
    // Plain load with data one cycle later
    next_cycle();
    lsu_en        = 1'b1;
    regfile_we    = 1'b1;
    regfile_waddr = addr_ok;
    @(negedge clk);
    check_bit("ex_valid_o", 1'b1, ex_valid);
    next_cycle();
    lsu_en     = 1'b0;
    regfile_we = 1'b0;
    lsu_rdata  = $urandom;
    @(negedge clk);
    exp = '{we: 1'b1, waddr: addr_ok, wdata: lsu_rdata};
    check_wr("wb_wr_o", exp, wb_wr);
    // Faulting load writes nothing and leaves the address alone
    next_cycle();
    lsu_en        = 1'b1;
    regfile_we    = 1'b1;
    regfile_waddr = addr_err;
    lsu_err       = 1'b1;
    next_cycle();
    lsu_en     = 1'b0;
    regfile_we = 1'b0;
    lsu_err    = 1'b0;
    lsu_rdata  = $urandom;
    @(negedge clk);
    exp = '{we: 1'b0, waddr: addr_ok, wdata: lsu_rdata};
    check_wr("wb_wr_o", exp, wb_wr);
    // Back-pressure from WB holds the slot
    next_cycle();
    lsu_en        = 1'b1;
    regfile_we    = 1'b1;
    regfile_waddr = addr_bp;
    next_cycle();
    lsu_en     = 1'b0;
    regfile_we = 1'b0;
    wb_ready   = 1'b0;
    lsu_rdata  = $urandom;
    @(negedge clk);
    exp = '{we: 1'b1, waddr: addr_bp, wdata: lsu_rdata};
    check_wr("wb_wr_o", exp, wb_wr);
    check_bit("ex_ready_o", 1'b0, ex_ready);
    for (int i = 0; i < 2; i++) begin
      next_cycle();
      @(negedge clk);
      check_wr("wb_wr_o", exp, wb_wr);
    end
    // Slot empties one edge after release
    next_cycle();
    wb_ready = 1'b1;
    @(negedge clk);
    check_wr("wb_wr_o", exp, wb_wr);
    next_cycle();
    @(negedge clk);
    exp.we = 1'b0;
    check_wr("wb_wr_o", exp, wb_wr);
    next_cycle();
    idle_inputs();
    finish_test();
  endtask

  task automatic test_priority();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] r;
    start_test("priority_ready");
    a = $urandom;
    b = $urandom;
    r = $urandom;
    next_cycle();
    alu_req.en  = 1'b1;
    alu_req.op  = ALU_XOR;
    alu_req.a   = a;
    alu_req.b   = b;
    mul_req.en  = 1'b1;
    mul_req.op  = MUL_LO;
    mul_req.a   = a;
    mul_req.b   = b;
    cml_req.get = 1'b1;
    csr_access  = 1'b1;
    csr_rdata   = r;
    @(negedge clk);
    check_word("fw_wr_o.wdata", r, fw_wr.wdata);
    // Drop sources one by one from the top
    next_cycle();
    csr_access = 1'b0;
    @(negedge clk);
    check_word("fw_wr_o.wdata", a * b, fw_wr.wdata);
    next_cycle();
    mul_req.en = 1'b0;
    @(negedge clk);
    // Accumulator left at zero by the accumulator test
    check_word("fw_wr_o.wdata", '0, fw_wr.wdata);
    next_cycle();
    cml_req.get = 1'b0;
    @(negedge clk);
    check_word("fw_wr_o.wdata", alu_ref(ALU_XOR, a, b), fw_wr.wdata);
    // Branch completes even with the LSU stalled
    next_cycle();
    alu_req.en   = 1'b0;
    lsu_ready_ex = 1'b0;
    branch_in_ex = 1'b1;
    @(negedge clk);
    check_bit("ex_ready_o", 1'b1, ex_ready);
    next_cycle();
    branch_in_ex = 1'b0;
    @(negedge clk);
    check_bit("ex_ready_o", 1'b0, ex_ready);
    next_cycle();
    idle_inputs();
    finish_test();
  endtask

  ////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    idle_inputs();
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset_state();
    test_alu_ops();
    test_branches();
    test_mult();
    test_accum();
    test_load_wb();
    test_priority();
    next_cycle();
    $display("Summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== ex_stage.f ====
+incdir+dv
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_mult.sv
hdl/ex_accum.sv
hdl/ex_wb_pipe.sv
hdl/ex_wr_mux.sv
hdl/ex_stage.sv
dv/tb_ex_stage.sv

// ==== hdl/ex_accum.sv ====
// Running sum accumulator
`timescale 1ns/10ps
`default_nettype none

module ex_accum
  import ex_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire cml_req_t        cml_req_i,
  output logic      [XLEN-1:0] result_o
);

  logic [XLEN-1:0] sum_q;
  logic [XLEN-1:0] pair_sum;

  // Both operands join the running sum in one step
  assign pair_sum = cml_req_i.a + cml_req_i.b;

  ////////////////////////////////////////
  // Sum register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_q <= '0;
    end else if (cml_req_i.clr) begin
      // Clear wins over accumulate
      sum_q <= '0;
    end else if (cml_req_i.en) begin
      sum_q <= sum_q + pair_sum;   // wraps modulo 2^XLEN
    end
  end

  // Read returns the stored value, get only selects it downstream
  assign result_o = sum_q;

endmodule

`default_nettype wire

// ==== hdl/ex_alu.sv ====
// Integer ALU with branch comparator
`timescale 1ns/10ps
`default_nettype none

module ex_alu
  import ex_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire alu_req_t        alu_req_i,
  output logic      [XLEN-1:0] result_o,
  output logic                 cmp_result_o
);

  logic            sub_sel;
  logic [XLEN-1:0] adder_b;
  logic [XLEN:0]   adder_sum;
  logic            is_eq;
  logic            lt_s;
  logic            lt_u;
  logic [SHAMT_W-1:0] shamt;

  ////////////////////////////////////////
  // Shared adder
  ////////////////////////////////////////

  // Subtract for SUB and every compare opcode
  always_comb begin
    case (alu_req_i.op)
      ALU_ADD, ALU_XOR, ALU_OR, ALU_AND,
      ALU_SLL, ALU_SRL, ALU_SRA: sub_sel = 1'b0;
      default:                   sub_sel = 1'b1;
    endcase
  end

  assign adder_b   = sub_sel ? ~alu_req_i.b : alu_req_i.b;
  // Carry in completes the two's complement
  assign adder_sum = {1'b0, alu_req_i.a} + {1'b0, adder_b} + {{XLEN{1'b0}}, sub_sel};

  ////////////////////////////////////////
  // Comparator
  ////////////////////////////////////////

  assign is_eq = (adder_sum[XLEN-1:0] == '0);
  // No borrow out means a >= b unsigned
  assign lt_u  = ~adder_sum[XLEN];
  // Differing signs decide directly, else the difference sign
  assign lt_s  = (alu_req_i.a[XLEN-1] ^ alu_req_i.b[XLEN-1]) ?
                 alu_req_i.a[XLEN-1] : adder_sum[XLEN-1];

  always_comb begin
    case (alu_req_i.op)
      ALU_EQ:          cmp_result_o = is_eq;
      ALU_NE:          cmp_result_o = ~is_eq;
      ALU_LT, ALU_SLT: cmp_result_o = lt_s;
      ALU_GE:          cmp_result_o = ~lt_s;
      ALU_LTU,
      ALU_SLTU:        cmp_result_o = lt_u;
      ALU_GEU:         cmp_result_o = ~lt_u;
      default:         cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Result select
  ////////////////////////////////////////

  assign shamt = alu_req_i.b[SHAMT_W-1:0];

  always_comb begin
    case (alu_req_i.op)
      ALU_ADD, ALU_SUB: result_o = adder_sum[XLEN-1:0];
      ALU_XOR:          result_o = alu_req_i.a ^ alu_req_i.b;
      ALU_OR:           result_o = alu_req_i.a | alu_req_i.b;
      ALU_AND:          result_o = alu_req_i.a & alu_req_i.b;
      ALU_SLL:          result_o = alu_req_i.a << shamt;
      ALU_SRL:          result_o = alu_req_i.a >> shamt;
      ALU_SRA:          result_o = $unsigned($signed(alu_req_i.a) >>> shamt);
      // Set-less-than and branch compares give a 0 or 1 word
      default:          result_o = {{(XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

  // Decoder must never enable the ALU with an unknown opcode
  a_op_legal: assert property (@(posedge clk) disable iff (!rst_n)
    alu_req_i.en |-> alu_req_i.op inside {ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR,
                                          ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
                                          ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE,
                                          ALU_LT, ALU_GE, ALU_LTU, ALU_GEU});

endmodule

`default_nettype wire

// ==== hdl/ex_mult.sv ====
// Integer multiplier with two-cycle high product
`timescale 1ns/10ps
`default_nettype none

module ex_mult
  import ex_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire mul_req_t        mul_req_i,
  input  wire logic            ex_ready_i,
  output logic      [XLEN-1:0] result_o,
  output logic                 multicycle_o,
  output logic                 ready_o
);

  logic                   hi_phase_q;
  logic                   hi_phase_d;
  logic [2*XLEN-1:0]      prod_q;
  logic signed [2*XLEN-1:0] full_prod;

  ////////////////////////////////////////
  // Product
  ////////////////////////////////////////

  // One signed multiplier serves both words
  // Low word is identical for signed and unsigned operands
  assign full_prod = $signed(mul_req_i.a) * $signed(mul_req_i.b);

  ////////////////////////////////////////
  // High product sequencing
  ////////////////////////////////////////

  // First cycle of MUL_HS registers the product and stalls the stage
  assign multicycle_o = mul_req_i.en & (mul_req_i.op == MUL_HS) & ~hi_phase_q;
  assign ready_o      = ~multicycle_o;

  always_comb begin
    hi_phase_d = hi_phase_q;
    if (multicycle_o) begin
      hi_phase_d = 1'b1;
    end else if (hi_phase_q && ex_ready_i) begin
      // Back to idle once the result is consumed
      hi_phase_d = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hi_phase_q <= 1'b0;
    end else begin
      hi_phase_q <= hi_phase_d;
    end
  end

  // Product holding register
  always_ff @(posedge clk) begin
    if (multicycle_o) begin
      prod_q <= full_prod;
    end
  end

  // High word from the register in the second cycle
  assign result_o = hi_phase_q ? prod_q[2*XLEN-1:XLEN] : full_prod[XLEN-1:0];

  // ID holds the high product request through the stall
  a_hs_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    multicycle_o |=> mul_req_i.en && (mul_req_i.op == MUL_HS) &&
                     $stable(mul_req_i.a) && $stable(mul_req_i.b));

endmodule

`default_nettype wire

// ==== hdl/ex_pkg.sv ====
// Execute stage shared definitions
`default_nettype none

package ex_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Data word of the core
  parameter int unsigned XLEN      = 32;
  // Register file address, includes the second bank bit
  parameter int unsigned RF_ADDR_W = 6;
  // Shift amount taken from operand b
  parameter int unsigned SHAMT_W   = $clog2(XLEN);

  ////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////

  // ALU operations, encoded as the ID stage decodes them
  typedef enum logic [6:0] {
    ALU_ADD  = 7'b0011000,
    ALU_SUB  = 7'b0011001,
    ALU_XOR  = 7'b0101111,
    ALU_OR   = 7'b0101110,
    ALU_AND  = 7'b0010101,
    ALU_SLL  = 7'b0100111,
    ALU_SRL  = 7'b0100101,
    ALU_SRA  = 7'b0100100,
    ALU_SLT  = 7'b0000010,
    ALU_SLTU = 7'b0000011,
    // Branch comparisons from here on
    ALU_EQ   = 7'b0001100,
    ALU_NE   = 7'b0001101,
    ALU_LT   = 7'b0000000,
    ALU_GE   = 7'b0001010,
    ALU_LTU  = 7'b0000001,
    ALU_GEU  = 7'b0001011
  } alu_op_e;

  // Multiplier operations
  typedef enum logic [0:0] {
    MUL_LO = 1'b0,   // low word, single cycle
    MUL_HS = 1'b1    // signed high word, two cycles
  } mul_op_e;

  ////////////////////////////////////////
  // Request and write port bundles
  ////////////////////////////////////////

  typedef struct packed {
    logic            en;
    alu_op_e         op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] c;      // Jump target for branches
  } alu_req_t;

  typedef struct packed {
    logic            en;
    mul_op_e         op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
  } mul_req_t;

  typedef struct packed {
    logic            en;
    logic            get;
    logic            clr;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
  } cml_req_t;

  // One register file write port
  typedef struct packed {
    logic                 we;
    logic [RF_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]      wdata;
  } rf_wr_t;

endpackage

`default_nettype wire

// ==== hdl/ex_stage.sv ====
// Execute stage top level
`timescale 1ns/10ps
`default_nettype none

module ex_stage
  import ex_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 rst_n,

  // Unit requests from ID
  input  wire alu_req_t             alu_req_i,
  input  wire mul_req_t             mul_req_i,
  input  wire cml_req_t             cml_req_i,

  // CSR read value
  input  wire logic                 csr_access_i,
  input  wire logic [XLEN-1:0]      csr_rdata_i,

  // Destinations
  input  wire logic                 regfile_alu_we_i,
  input  wire logic [RF_ADDR_W-1:0] regfile_alu_waddr_i,
  input  wire logic                 regfile_we_i,
  input  wire logic [RF_ADDR_W-1:0] regfile_waddr_i,

  // Load store unit
  input  wire logic                 lsu_en_i,
  input  wire logic [XLEN-1:0]      lsu_rdata_i,
  input  wire logic                 lsu_ready_ex_i,
  input  wire logic                 lsu_err_i,

  input  wire logic                 branch_in_ex_i,
  input  wire logic                 wb_ready_i,

  // Write ports
  output rf_wr_t                    fw_wr_o,
  output rf_wr_t                    wb_wr_o,

  // To IF
  output logic      [XLEN-1:0]      jump_target_o,
  output logic                      branch_decision_o,

  output logic                      mult_multicycle_o,
  output logic                      ex_ready_o,
  output logic                      ex_valid_o
);

  logic [XLEN-1:0]      alu_result;
  logic                 alu_cmp;
  logic [XLEN-1:0]      mult_result;
  logic                 mult_ready;
  logic [XLEN-1:0]      cml_result;
  logic                 cml_sel;
  logic                 lsu_we;
  logic [RF_ADDR_W-1:0] lsu_waddr;

  ////////////////////////////////////////
  // Execution units
  ////////////////////////////////////////

  ex_alu alu_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .alu_req_i    (alu_req_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp)
  );

  // Branch outcome comes straight from the comparator
  assign branch_decision_o = alu_cmp;
  assign jump_target_o     = alu_req_i.c;

  ex_mult mult_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .mul_req_i    (mul_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  ex_accum cml_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cml_req_i (cml_req_i),
    .result_o  (cml_result)
  );

  // Accumulator drives the port on update or read
  assign cml_sel = cml_req_i.en | cml_req_i.get;

  ////////////////////////////////////////
  // Stage control and EX/WB register
  ////////////////////////////////////////

  ex_wb_pipe pipe_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .alu_en_i        (alu_req_i.en),
    .mult_en_i       (mul_req_i.en),
    .csr_access_i    (csr_access_i),
    .lsu_en_i        (lsu_en_i),
    .mult_ready_i    (mult_ready),
    .lsu_ready_ex_i  (lsu_ready_ex_i),
    .lsu_err_i       (lsu_err_i),
    .branch_in_ex_i  (branch_in_ex_i),
    .wb_ready_i      (wb_ready_i),
    .regfile_we_i    (regfile_we_i),
    .regfile_waddr_i (regfile_waddr_i),
    .ex_ready_o      (ex_ready_o),
    .ex_valid_o      (ex_valid_o),
    .lsu_we_o        (lsu_we),
    .lsu_waddr_o     (lsu_waddr)
  );

  ////////////////////////////////////////
  // Write port mux
  ////////////////////////////////////////

  ex_wr_mux wr_mux_i (
    .alu_result_i        (alu_result),
    .cml_result_i        (cml_result),
    .mult_result_i       (mult_result),
    .csr_rdata_i         (csr_rdata_i),
    .alu_en_i            (alu_req_i.en),
    .cml_sel_i           (cml_sel),
    .mult_en_i           (mul_req_i.en),
    .csr_access_i        (csr_access_i),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .lsu_we_i            (lsu_we),
    .lsu_waddr_i         (lsu_waddr),
    .lsu_rdata_i         (lsu_rdata_i),
    .fw_wr_o             (fw_wr_o),
    .wb_wr_o             (wb_wr_o)
  );

endmodule

`default_nettype wire

// ==== hdl/ex_wb_pipe.sv ====
// Stage control and EX/WB load register
`timescale 1ns/10ps
`default_nettype none

module ex_wb_pipe
  import ex_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 alu_en_i,
  input  wire logic                 mult_en_i,
  input  wire logic                 csr_access_i,
  input  wire logic                 lsu_en_i,
  input  wire logic                 mult_ready_i,
  input  wire logic                 lsu_ready_ex_i,
  input  wire logic                 lsu_err_i,
  input  wire logic                 branch_in_ex_i,
  input  wire logic                 wb_ready_i,
  input  wire logic                 regfile_we_i,
  input  wire logic [RF_ADDR_W-1:0] regfile_waddr_i,
  output logic                      ex_ready_o,
  output logic                      ex_valid_o,
  output logic                      lsu_we_o,
  output logic      [RF_ADDR_W-1:0] lsu_waddr_o
);

  logic units_done;
  logic load_we;

  ////////////////////////////////////////
  // Ready and valid
  ////////////////////////////////////////

  // All units and the WB side can take the result
  assign units_done = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // Branches finish in EX and never wait for WB
  assign ex_ready_o = units_done | branch_in_ex_i;
  // Valid goes right and ready goes left, so valid ignores ex_ready
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_done;

  ////////////////////////////////////////
  // EX/WB load destination
  ////////////////////////////////////////

  // Faulting loads never write back
  assign load_we = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_o <= 1'b0;
    end else if (ex_valid_o) begin
      lsu_we_o <= load_we;
    end else if (wb_ready_i) begin
      // Bubble flushes the slot
      lsu_we_o <= 1'b0;
    end
  end

  // Address only follows real writes
  always_ff @(posedge clk) begin
    if (ex_valid_o && load_we) begin
      lsu_waddr_o <= regfile_waddr_i;
    end
  end

  // Back-pressure from WB never loses or changes the slot
  a_slot_held: assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i |=> $stable(lsu_we_o) && $stable(lsu_waddr_o));

endmodule

`default_nettype wire

// ==== hdl/ex_wr_mux.sv ====
// Register file write port select
`timescale 1ns/10ps
`default_nettype none

module ex_wr_mux
  import ex_pkg::*;
(
  input  wire logic [XLEN-1:0]      alu_result_i,
  input  wire logic [XLEN-1:0]      cml_result_i,
  input  wire logic [XLEN-1:0]      mult_result_i,
  input  wire logic [XLEN-1:0]      csr_rdata_i,
  input  wire logic                 alu_en_i,
  input  wire logic                 cml_sel_i,
  input  wire logic                 mult_en_i,
  input  wire logic                 csr_access_i,
  input  wire logic                 regfile_alu_we_i,
  input  wire logic [RF_ADDR_W-1:0] regfile_alu_waddr_i,
  input  wire logic                 lsu_we_i,
  input  wire logic [RF_ADDR_W-1:0] lsu_waddr_i,
  input  wire logic [XLEN-1:0]      lsu_rdata_i,
  output rf_wr_t                    fw_wr_o,
  output rf_wr_t                    wb_wr_o
);

  ////////////////////////////////////////
  // Forwarding port
  ////////////////////////////////////////

  // Later assignments win
  // Order gives CSR, then multiplier, accumulator, ALU
  always_comb begin
    fw_wr_o.we    = regfile_alu_we_i;
    fw_wr_o.waddr = regfile_alu_waddr_i;
    fw_wr_o.wdata = '0;
    if (alu_en_i) begin
      fw_wr_o.wdata = alu_result_i;
    end
    if (cml_sel_i) begin
      fw_wr_o.wdata = cml_result_i;
    end
    if (mult_en_i) begin
      fw_wr_o.wdata = mult_result_i;
    end
    if (csr_access_i) begin
      fw_wr_o.wdata = csr_rdata_i;
    end
  end

  ////////////////////////////////////////
  // Load write back port
  ////////////////////////////////////////

  // Destination registered a cycle earlier, data arrives now
  always_comb begin
    wb_wr_o.we    = lsu_we_i;
    wb_wr_o.waddr = lsu_waddr_i;
    wb_wr_o.wdata = lsu_rdata_i;
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ex_stage -f ex_stage.f \
  --Mdir obj_dir -o tb_ex_stage

./obj_dir/tb_ex_stage | tee sim.log

if grep -q "Simulation passed" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
